// ==== build.f ====
src/bpu_pkg.sv
src/bpu_update_if.sv
src/cf_decode.sv
src/branch_target_buffer.sv
src/gshare_predictor.sv
src/return_stack.sv
src/bpu_top.sv
testbench/bpu_clock_gen.sv
testbench/bpu_tb.sv

// ==== Bender.yml ====
package:
  name: bpu

sources:
  - src/bpu_pkg.sv
  - src/bpu_update_if.sv
  - src/cf_decode.sv
  - src/branch_target_buffer.sv
  - src/gshare_predictor.sv
  - src/return_stack.sv
  - src/bpu_top.sv
  - target: test
    files:
      - testbench/bpu_clock_gen.sv
      - testbench/bpu_tb.sv

// ==== testbench/bpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bpu_tb;

    localparam int WAIT_LIMIT = 200;
    localparam bpu_pkg::inst_t NOP = 32'h0000_0013;
    localparam bpu_pkg::inst_t RET = 32'h0000_8067;
    localparam bpu_pkg::inst_t CALL = 32'h0080_00ef;

    typedef struct packed {
        logic           is_cf;
        logic           taken;
        bpu_pkg::xlen_t target;
        bpu_pkg::hist_t hist;
    } pred_t;

    wire clk;
    wire rst;

    logic           req_valid_i;
    wire            req_ready_o;
    bpu_pkg::xlen_t req_pc_i;
    bpu_pkg::inst_t req_inst_i;
    wire            rsp_valid_o;
    logic           rsp_ready_i;
    wire            rsp_is_cf_o;
    wire            rsp_taken_o;
    bpu_pkg::xlen_t rsp_target_o;
    bpu_pkg::hist_t rsp_history_o;
    logic           upd_valid_i;
    bpu_pkg::xlen_t upd_pc_i;
    bpu_pkg::inst_t upd_inst_i;
    logic           upd_taken_i;
    bpu_pkg::xlen_t upd_target_i;
    bpu_pkg::hist_t upd_history_i;
    logic           flush_i;
    bpu_pkg::hist_t flush_history_i;

    // reference model state
    logic [255:0]      m_btb_valid;
    logic [13:0]       m_btb_tag [256];
    bpu_pkg::xlen_t    m_btb_tgt [256];
    logic [1:0]        m_ctr [256];
    bpu_pkg::hist_t    m_hist;
    bpu_pkg::xlen_t    m_ras [$];
    pred_t             exp_q [$];
    pred_t             exp_head;
    logic              exp_valid;

    logic [31:0] seed = 32'd81595;
    int err_cnt = 0;
    int chk_cnt = 0;
    int acc_cnt = 0;
    int test_cnt = 0;
    int test_err_start = 0;
    logic bp_done;

    bpu_clock_gen i_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bpu_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_pc_i        (req_pc_i),
        .req_inst_i      (req_inst_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_is_cf_o     (rsp_is_cf_o),
        .rsp_taken_o     (rsp_taken_o),
        .rsp_target_o    (rsp_target_o),
        .rsp_history_o   (rsp_history_o),
        .upd_valid_i     (upd_valid_i),
        .upd_pc_i        (upd_pc_i),
        .upd_inst_i      (upd_inst_i),
        .upd_taken_i     (upd_taken_i),
        .upd_target_i    (upd_target_i),
        .upd_history_i   (upd_history_i),
        .flush_i         (flush_i),
        .flush_history_i (flush_history_i)
    );

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // rv32 control-flow classes
    function automatic bpu_pkg::cf_kind_e kind_of(input bpu_pkg::inst_t inst);
        if (inst[6:0] == bpu_pkg::OPC_BRANCH) return bpu_pkg::CF_BRANCH;
        if (inst[6:0] == bpu_pkg::OPC_JAL) return bpu_pkg::CF_CALL_DIRECT;
        if (inst[6:0] != bpu_pkg::OPC_JALR) return bpu_pkg::CF_NONE;
        if (inst[11:7] != 5'd0) return bpu_pkg::CF_CALL_INDIRECT;
        if (inst[19:15] == 5'd1) return bpu_pkg::CF_RETURN;
        return bpu_pkg::CF_JUMP_INDIRECT;
    endfunction

    // immediate as a weighted sum of its fields, sign bit counts negative
    function automatic bpu_pkg::xlen_t offset_of(input bpu_pkg::inst_t inst);
        bpu_pkg::xlen_t off;
        if (inst[6:0] == bpu_pkg::OPC_BRANCH) begin
            off = 32'(inst[11:8]) * 32'd2 + 32'(inst[30:25]) * 32'd32
                + 32'(inst[7]) * 32'd2048;
            if (inst[31]) off = off - 32'd4096;
        end else begin
            off = 32'(inst[30:21]) * 32'd2 + 32'(inst[20]) * 32'd2048
                + 32'(inst[19:12]) * 32'd4096;
            if (inst[31]) off = off - 32'h0010_0000;
        end
        return off;
    endfunction

    function automatic pred_t predict(input bpu_pkg::xlen_t pc, input bpu_pkg::inst_t inst);
        pred_t             p;
        bpu_pkg::cf_kind_e k;
        logic [7:0]        idx;
        logic              hit;
        k   = kind_of(inst);
        idx = pc[9:2];
        hit = m_btb_valid[idx] && (m_btb_tag[idx] == pc[31:18]);
        p.is_cf  = (k != bpu_pkg::CF_NONE);
        p.taken  = 1'b0;
        p.target = pc + 32'd4;
        p.hist   = m_hist;
        if (k == bpu_pkg::CF_CALL_DIRECT) begin
            p.taken  = 1'b1;
            p.target = pc + offset_of(inst);
        end else if (k == bpu_pkg::CF_RETURN && m_ras.size() > 0) begin
            p.taken  = 1'b1;
            p.target = m_ras[$];
        end else if (k == bpu_pkg::CF_BRANCH) begin
            if (m_ctr[idx ^ m_hist][1]) begin
                p.taken  = 1'b1;
                p.target = hit ? m_btb_tgt[idx] : pc + offset_of(inst);
            end
        end else if (k != bpu_pkg::CF_NONE && hit) begin
            p.taken  = 1'b1;
            p.target = m_btb_tgt[idx];
        end
        return p;
    endfunction

    task automatic reset_model();
        m_btb_valid = '0;
        for (int i = 0; i < 256; i++) begin
            m_ctr[i] = bpu_pkg::CTR_INIT;
        end
        m_hist = '0;
        m_ras.delete();
        exp_q.delete();
    endtask

    task automatic train_model();
        bpu_pkg::cf_kind_e k;
        logic [7:0]        ci;
        k  = kind_of(upd_inst_i);
        ci = upd_pc_i[9:2] ^ upd_history_i;
        if (upd_taken_i && k != bpu_pkg::CF_NONE) begin
            m_btb_valid[upd_pc_i[9:2]] = 1'b1;
            m_btb_tag[upd_pc_i[9:2]]   = upd_pc_i[31:18];
            m_btb_tgt[upd_pc_i[9:2]]   = upd_target_i;
        end
        if (k == bpu_pkg::CF_BRANCH) begin
            if (upd_taken_i && m_ctr[ci] != 2'b11) m_ctr[ci] = m_ctr[ci] + 2'b01;
            if (!upd_taken_i && m_ctr[ci] != 2'b00) m_ctr[ci] = m_ctr[ci] - 2'b01;
            m_hist = {m_hist[6:0], upd_taken_i};
        end
        if (k == bpu_pkg::CF_CALL_DIRECT || k == bpu_pkg::CF_CALL_INDIRECT) begin
            // overflow restarts the stack at one entry
            if (m_ras.size() == bpu_pkg::RAS_DEPTH) m_ras.delete();
            m_ras.push_back(upd_pc_i + 32'd4);
        end else if (k == bpu_pkg::CF_RETURN && m_ras.size() > 0) begin
            void'(m_ras.pop_back());
        end
    endtask

    // model sees the same pre-edge values as the DUT
    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            if (rsp_valid_o && rsp_ready_i && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                chk_cnt++;
            end
            if (flush_i) begin
                exp_q.delete();
            end else if (req_valid_i && req_ready_o) begin
                exp_q.push_back(predict(req_pc_i, req_inst_i));
                acc_cnt++;
            end
            if (upd_valid_i) train_model();
            if (flush_i) m_hist = flush_history_i;
        end
        exp_valid <= (exp_q.size() > 0);
        if (exp_q.size() > 0) exp_head <= exp_q[0];
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        err_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("check failed: %s", msg);
        err_cnt++;
    endtask

    chk_after_reset: assert property (@(posedge clk) $fell(rst) |-> !rsp_valid_o && req_ready_o)
        else report_failure("response valid or request not ready after reset");
    chk_no_extra: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && rsp_ready_i) |-> exp_valid)
        else report_failure("response transferred with no request pending");
    chk_is_cf: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && rsp_ready_i && exp_valid) |-> rsp_is_cf_o == exp_head.is_cf)
        else report_value("rsp_is_cf_o", $sampled(rsp_is_cf_o), $sampled(exp_head.is_cf));
    chk_taken: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && rsp_ready_i && exp_valid) |-> rsp_taken_o == exp_head.taken)
        else report_value("rsp_taken_o", $sampled(rsp_taken_o), $sampled(exp_head.taken));
    chk_target: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && rsp_ready_i && exp_valid) |-> rsp_target_o == exp_head.target)
        else report_value("rsp_target_o", $sampled(rsp_target_o), $sampled(exp_head.target));
    chk_history: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && rsp_ready_i && exp_valid) |-> rsp_history_o == exp_head.hist)
        else report_value("rsp_history_o", $sampled(rsp_history_o), $sampled(exp_head.hist));
    chk_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && !rsp_ready_i && !flush_i) |=> rsp_valid_o &&
            $stable({rsp_is_cf_o, rsp_taken_o, rsp_target_o, rsp_history_o}))
        else report_failure("response changed while stalled");
    chk_stall_ready: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_o && !rsp_ready_i) |-> !req_ready_o)
        else report_failure("request accepted while response stalled");
    chk_flush: assert property (@(posedge clk) disable iff (rst) flush_i |=> !rsp_valid_o)
        else report_failure("response still valid after flush");

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic issue(input bpu_pkg::xlen_t pc, input bpu_pkg::inst_t inst);
        int n;
        n = 0;
        req_valid_i <= 1'b1;
        req_pc_i    <= pc;
        req_inst_i  <= inst;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_fail("request acceptance");
        end while (!req_ready_o);
    endtask

    task automatic drain();
        int n;
        n = 0;
        req_valid_i <= 1'b0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_fail("response transfer");
        end while (rsp_valid_o);
    endtask

    task automatic send(input bpu_pkg::xlen_t pc, input bpu_pkg::inst_t inst);
        issue(pc, inst);
        drain();
    endtask

    task automatic post_update(input bpu_pkg::xlen_t pc, input bpu_pkg::inst_t inst,
                               input logic taken, input bpu_pkg::xlen_t target);
        upd_valid_i   <= 1'b1;
        upd_pc_i      <= pc;
        upd_inst_i    <= inst;
        upd_taken_i   <= taken;
        upd_target_i  <= target;
        upd_history_i <= 8'h00;
        @(posedge clk);
        upd_valid_i <= 1'b0;
    endtask

    task automatic pulse_flush(input bpu_pkg::hist_t h);
        flush_i         <= 1'b1;
        flush_history_i <= h;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_start);
        test_err_start = err_cnt;
    endtask

    initial begin
        bpu_pkg::xlen_t pc;
        bpu_pkg::inst_t inst;
        logic [31:0]    rnd;
        int n;
        req_valid_i     = 1'b0;
        req_pc_i        = '0;
        req_inst_i      = '0;
        rsp_ready_i     = 1'b1;
        upd_valid_i     = 1'b0;
        upd_pc_i        = '0;
        upd_inst_i      = '0;
        upd_taken_i     = 1'b0;
        upd_target_i    = '0;
        upd_history_i   = '0;
        flush_i         = 1'b0;
        flush_history_i = '0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) timeout_fail("reset release");
        end while (rst);

        send(32'h0000_1000, NOP);
        end_test("reset and non-control");

        rnd  = next_random();
        pc   = {rnd[31:2], 2'b00};
        rnd  = next_random();
        inst = {rnd[31:12], 5'd1, bpu_pkg::OPC_JAL};
        send(pc, inst);
        pc   = 32'h0000_2010;
        inst = {12'h000, 5'd5, 3'b000, 5'd0, bpu_pkg::OPC_JALR};
        send(pc, inst);
        post_update(pc, inst, 1'b1, 32'h0000_5a00);
        send(pc, inst);
        end_test("jal and jalr");

        for (int i = 0; i < 12; i++) begin
            rnd  = next_random();
            pc   = {rnd[31:2], 2'b00};
            rnd  = next_random();
            inst = {rnd[31:7], bpu_pkg::OPC_BRANCH};
            send(pc, inst);
            rnd = next_random();
            post_update(pc, inst, 1'b1, {rnd[31:2], 2'b00});
            rnd = next_random();
            post_update(pc, inst, 1'b1, {rnd[31:2], 2'b00});
            // back to the history that trained the counter
            pulse_flush(8'h00);
            send(pc, inst);
        end
        end_test("gshare branches");

        for (int i = 0; i < 3; i++) post_update(32'h0001_0000 + i * 32, CALL, 1'b1, 32'h0);
        for (int i = 0; i < 2; i++) begin
            send(32'h0002_0000, RET);
            post_update(32'h0002_0000, RET, 1'b1, 32'h0003_0000);
        end
        for (int i = 0; i < 10; i++) post_update(32'h0001_4000 + i * 32, CALL, 1'b1, 32'h0);
        for (int i = 0; i < 4; i++) begin
            send(32'h0002_0000, RET);
            post_update(32'h0002_0000, RET, 1'b1, 32'h0003_0000);
        end
        send(32'h0002_1000, RET);
        end_test("return stack");

        bp_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 24; i++) issue(32'h0000_4000 + i * 4, NOP);
                drain();
                bp_done = 1'b1;
            end
            begin
                while (!bp_done) begin
                    rnd = next_random();
                    rsp_ready_i <= (rnd[17:16] == 2'b00);
                    @(posedge clk);
                end
            end
        join
        rsp_ready_i <= 1'b1;
        if (acc_cnt != chk_cnt || exp_q.size() != 0) begin
            report_failure("accepted requests and transferred responses differ");
        end
        end_test("back-pressure");

        rsp_ready_i <= 1'b0;
        issue(32'h0000_6000, NOP);
        req_valid_i <= 1'b0;
        pulse_flush(8'ha5);
        rsp_ready_i <= 1'b1;
        send(32'h0000_6004, NOP);
        end_test("flush");

        $display("tests %0d, responses checked %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/bpu_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module bpu_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/bpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bpu_top (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    input  wire bpu_pkg::xlen_t     req_pc_i,
    input  wire bpu_pkg::inst_t     req_inst_i,

    output logic                    rsp_valid_o,
    input  wire                     rsp_ready_i,
    output logic                    rsp_is_cf_o,
    output logic                    rsp_taken_o,
    output bpu_pkg::xlen_t          rsp_target_o,
    output bpu_pkg::hist_t          rsp_history_o,

    input  wire                     upd_valid_i,
    input  wire bpu_pkg::xlen_t     upd_pc_i,
    input  wire bpu_pkg::inst_t     upd_inst_i,
    input  wire                     upd_taken_i,
    input  wire bpu_pkg::xlen_t     upd_target_i,
    input  wire bpu_pkg::hist_t     upd_history_i,
    input  wire                     flush_i,
    input  wire bpu_pkg::hist_t     flush_history_i
);

    bpu_update_if upd_bus ();

    bpu_pkg::cf_kind_e fetch_kind;
    bpu_pkg::xlen_t    fetch_offset;
    bpu_pkg::xlen_t    pc_plus4;
    logic              btb_hit;
    bpu_pkg::xlen_t    btb_target;
    logic              gshare_taken;
    bpu_pkg::hist_t    ghist;
    logic              ras_valid;
    bpu_pkg::xlen_t    ras_top;
    logic              pred_is_cf;
    logic              pred_taken;
    bpu_pkg::xlen_t    pred_target;
    logic              req_fire;

    cf_decode i_fetch_decode (
        .inst_i   (req_inst_i),
        .kind_o   (fetch_kind),
        .offset_o (fetch_offset)
    );

    // resolved instruction only needs its kind
    cf_decode i_upd_decode (
        .inst_i   (upd_inst_i),
        .kind_o   (upd_bus.kind),
        .offset_o ()
    );

    assign upd_bus.valid   = upd_valid_i;
    assign upd_bus.pc      = upd_pc_i;
    assign upd_bus.taken   = upd_taken_i;
    assign upd_bus.target  = upd_target_i;
    assign upd_bus.history = upd_history_i;

    branch_target_buffer i_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (req_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .upd         (upd_bus)
    );

    gshare_predictor i_gshare (
        .clk             (clk),
        .rst             (rst),
        .lookup_pc_i     (req_pc_i),
        .flush_i         (flush_i),
        .flush_history_i (flush_history_i),
        .taken_o         (gshare_taken),
        .history_o       (ghist),
        .upd             (upd_bus)
    );

    return_stack i_ras (
        .clk         (clk),
        .rst         (rst),
        .top_valid_o (ras_valid),
        .top_o       (ras_top),
        .upd         (upd_bus)
    );

    assign pc_plus4 = req_pc_i + bpu_pkg::xlen_t'(4);

    always_comb begin
        pred_is_cf  = (fetch_kind != bpu_pkg::CF_NONE);
        pred_taken  = 1'b0;
        pred_target = pc_plus4;
        case (fetch_kind)
            bpu_pkg::CF_CALL_DIRECT: begin
                pred_taken  = 1'b1;
                pred_target = req_pc_i + fetch_offset;
            end
            bpu_pkg::CF_RETURN: begin
                // stack first, btb as fallback
                if (ras_valid) begin
                    pred_taken  = 1'b1;
                    pred_target = ras_top;
                end else if (btb_hit) begin
                    pred_taken  = 1'b1;
                    pred_target = btb_target;
                end
            end
            bpu_pkg::CF_CALL_INDIRECT, bpu_pkg::CF_JUMP_INDIRECT: begin
                if (btb_hit) begin
                    pred_taken  = 1'b1;
                    pred_target = btb_target;
                end
            end
            bpu_pkg::CF_BRANCH: begin
                if (gshare_taken) begin
                    pred_taken  = 1'b1;
                    pred_target = btb_hit ? btb_target : req_pc_i + fetch_offset;
                end
            end
            default: begin
                pred_taken = 1'b0;
            end
        endcase
    end

    assign req_ready_o = !rsp_valid_o || rsp_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_o <= 1'b0;
        end else if (flush_i) begin
            rsp_valid_o <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_is_cf_o   <= pred_is_cf;
            rsp_taken_o   <= pred_taken;
            rsp_target_o  <= pred_target;
            rsp_history_o <= ghist;
        end
    end

    rsp_stable: assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid_o && !rsp_ready_i && !flush_i) |=>
            (rsp_valid_o &&
             $stable({rsp_is_cf_o, rsp_taken_o, rsp_target_o, rsp_history_o}))
    );

endmodule

`default_nettype wire

// ==== src/return_stack.sv ====
`timescale 1ns/10ps
`default_nettype none

module return_stack (
    input  wire             clk,
    input  wire             rst,
    output logic            top_valid_o,
    output bpu_pkg::xlen_t  top_o,
    bpu_update_if.sink      upd
);

    bpu_pkg::xlen_t    ras_q [bpu_pkg::RAS_DEPTH];
    bpu_pkg::ras_cnt_t depth_q;

    logic                          push;
    logic                          pop;
    logic                          full;
    logic [bpu_pkg::RAS_IDX_W-1:0] push_idx;
    logic [bpu_pkg::RAS_IDX_W-1:0] top_idx;

    assign push = upd.valid && ((upd.kind == bpu_pkg::CF_CALL_DIRECT) ||
                                (upd.kind == bpu_pkg::CF_CALL_INDIRECT));
    assign pop  = upd.valid && (upd.kind == bpu_pkg::CF_RETURN) && (depth_q != '0);
    assign full = (depth_q == bpu_pkg::RAS_FULL);

    // wrap to entry 0 when full
    assign push_idx = full ? '0 : depth_q[bpu_pkg::RAS_IDX_W-1:0];
    assign top_idx  = depth_q[bpu_pkg::RAS_IDX_W-1:0] - 1'b1;

    assign top_valid_o = (depth_q != '0);
    assign top_o       = ras_q[top_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            depth_q <= '0;
        end else if (push) begin
            depth_q <= full ? bpu_pkg::ras_cnt_t'(1) : depth_q + 1'b1;
        end else if (pop) begin
            depth_q <= depth_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ras_q[push_idx] <= upd.pc + bpu_pkg::xlen_t'(4);
        end
    end

    depth_bounded: assert property (
        @(posedge clk) disable iff (rst) depth_q <= bpu_pkg::RAS_FULL
    );

endmodule

`default_nettype wire

// ==== src/gshare_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module gshare_predictor (
    input  wire                     clk,
    input  wire                     rst,
    input  wire bpu_pkg::xlen_t     lookup_pc_i,
    input  wire                     flush_i,
    input  wire bpu_pkg::hist_t     flush_history_i,
    output logic                    taken_o,
    output bpu_pkg::hist_t          history_o,
    bpu_update_if.sink              upd
);

    bpu_pkg::ctr_t  pht_q [bpu_pkg::PHT_ENTRIES];
    bpu_pkg::hist_t hist_q;

    logic [bpu_pkg::PHT_IDX_W-1:0] lookup_idx;
    logic [bpu_pkg::PHT_IDX_W-1:0] upd_idx;
    logic                          br_upd;
    bpu_pkg::ctr_t                 ctr_cur;
    bpu_pkg::ctr_t                 ctr_next;

    // gshare index
    assign lookup_idx = lookup_pc_i[bpu_pkg::PHT_IDX_W+1:2] ^ hist_q;
    assign upd_idx    = upd.pc[bpu_pkg::PHT_IDX_W+1:2] ^ upd.history;

    assign taken_o   = pht_q[lookup_idx][1];
    assign history_o = hist_q;

    assign br_upd  = upd.valid && (upd.kind == bpu_pkg::CF_BRANCH);
    assign ctr_cur = pht_q[upd_idx];

    // saturating step toward the outcome
    always_comb begin
        ctr_next = ctr_cur;
        if (upd.taken && (ctr_cur != 2'b11)) begin
            ctr_next = ctr_cur + 2'b01;
        end else if (!upd.taken && (ctr_cur != 2'b00)) begin
            ctr_next = ctr_cur - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::PHT_ENTRIES; i++) begin
                pht_q[i] <= bpu_pkg::CTR_INIT;
            end
        end else if (br_upd) begin
            pht_q[upd_idx] <= ctr_next;
        end
    end

    // flush restores the history, newest outcome in bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            hist_q <= '0;
        end else if (flush_i) begin
            hist_q <= flush_history_i;
        end else if (br_upd) begin
            hist_q <= {hist_q[bpu_pkg::HIST_W-2:0], upd.taken};
        end
    end

endmodule

`default_nettype wire

// ==== src/branch_target_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire bpu_pkg::xlen_t     lookup_pc_i,
    output logic                    hit_o,
    output bpu_pkg::xlen_t          target_o,
    bpu_update_if.sink              upd
);

    logic [bpu_pkg::BTB_ENTRIES-1:0] valid_q;
    bpu_pkg::btb_tag_t               tag_q    [bpu_pkg::BTB_ENTRIES];
    bpu_pkg::xlen_t                  target_q [bpu_pkg::BTB_ENTRIES];

    logic [bpu_pkg::BTB_IDX_W-1:0] lookup_idx;
    logic [bpu_pkg::BTB_IDX_W-1:0] upd_idx;
    bpu_pkg::btb_tag_t             lookup_tag;
    bpu_pkg::btb_tag_t             upd_tag;
    logic                          wr_en;

    // index from pc[9:2], tag from the top bits
    assign lookup_idx = lookup_pc_i[bpu_pkg::BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
    assign upd_idx    = upd.pc[bpu_pkg::BTB_IDX_W+1:2];
    assign upd_tag    = upd.pc[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];

    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    // only taken control flow allocates
    assign wr_en = upd.valid && upd.taken && (upd.kind != bpu_pkg::CF_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd.target;
        end
    end

endmodule

`default_nettype wire

// ==== src/cf_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module cf_decode (
    input  wire bpu_pkg::inst_t     inst_i,
    output bpu_pkg::cf_kind_e       kind_o,
    output bpu_pkg::xlen_t          offset_o
);

    logic [4:0] rd;
    logic [4:0] rs1;

    assign rd  = inst_i[11:7];
    assign rs1 = inst_i[19:15];

    always_comb begin
        kind_o   = bpu_pkg::CF_NONE;
        offset_o = '0;
        case (inst_i[6:0])
            bpu_pkg::OPC_BRANCH: begin
                kind_o   = bpu_pkg::CF_BRANCH;
                offset_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            bpu_pkg::OPC_JAL: begin
                kind_o   = bpu_pkg::CF_CALL_DIRECT;
                offset_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            bpu_pkg::OPC_JALR: begin
                // jalr x0, 0(ra) is the return idiom
                if (rd != 5'd0) begin
                    kind_o = bpu_pkg::CF_CALL_INDIRECT;
                end else if (rs1 == 5'd1) begin
                    kind_o = bpu_pkg::CF_RETURN;
                end else begin
                    kind_o = bpu_pkg::CF_JUMP_INDIRECT;
                end
            end
            default: begin
                kind_o = bpu_pkg::CF_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/bpu_update_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one resolved control-flow instruction, already decoded
interface bpu_update_if;

    logic               valid;
    bpu_pkg::xlen_t     pc;
    bpu_pkg::cf_kind_e  kind;
    logic               taken;
    bpu_pkg::xlen_t     target;
    bpu_pkg::hist_t     history;

    modport source (
        output valid,
        output pc,
        output kind,
        output taken,
        output target,
        output history
    );

    modport sink (
        input valid,
        input pc,
        input kind,
        input taken,
        input target,
        input history
    );

endinterface

`default_nettype wire

// ==== src/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    localparam int XLEN   = 32;
    localparam int HIST_W = 8;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [31:0]       inst_t;
    typedef logic [HIST_W-1:0] hist_t;

    // control-flow kind of one instruction
    typedef enum logic [2:0] {
        CF_NONE,
        CF_BRANCH,
        CF_CALL_DIRECT,
        CF_CALL_INDIRECT,
        CF_RETURN,
        CF_JUMP_INDIRECT
    } cf_kind_e;

    // btb, indexed by pc[9:2]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = 14;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // pattern history table, index width equals history width
    localparam int PHT_ENTRIES = 256;
    localparam int PHT_IDX_W   = $clog2(PHT_ENTRIES);
    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_INIT = 2'b01;

    // return address stack
    localparam int RAS_DEPTH = 8;
    localparam int RAS_IDX_W = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_W = $clog2(RAS_DEPTH + 1);
    typedef logic [RAS_CNT_W-1:0] ras_cnt_t;
    localparam ras_cnt_t RAS_FULL = RAS_CNT_W'(RAS_DEPTH);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire
